//--- Bender.yml
package:
  name: cdc_fifo

dependencies: {}

sources:
  # Packages come first
  - hw/fifo_data_pkg.sv
  - hw/fifo_ptr_pkg.sv

  # RTL
  - hw/fifo_mem.sv
  - hw/gray_sync.sv
  - hw/fifo_level.sv
  - hw/fifo_ctrl.sv
  - hw/cdc_fifo_top.sv

  # Testbench
  - target: simulation
    files:
      - verif/cdc_fifo_tb.sv

//--- files.f
hw/fifo_data_pkg.sv
hw/fifo_ptr_pkg.sv
hw/fifo_mem.sv
hw/gray_sync.sv
hw/fifo_level.sv
hw/fifo_ctrl.sv
hw/cdc_fifo_top.sv
verif/cdc_fifo_tb.sv

//--- hw/cdc_fifo_top.sv
`timescale 1ns/1ps

module cdc_fifo_top (
    input  logic                               wclk,
    input  logic                               wrstn,
    input  logic                               winc,
    input  logic [fifo_data_pkg::DATA_WIDTH-1:0] wdata,
    output logic                               wfull,
    input  logic                               rclk,
    input  logic                               rrstn,
    input  logic                               rinc,
    output logic [fifo_data_pkg::DATA_WIDTH-1:0] rdata,
    output logic                               rempty,
    output logic [fifo_ptr_pkg::LEVEL_WIDTH-1:0] rlevel
);
    import fifo_ptr_pkg::*;

    logic                  wen;
    logic                  ren;
    logic [ADDR_WIDTH-1:0] waddr;
    logic [ADDR_WIDTH-1:0] raddr;
    logic [PTR_WIDTH-1:0]  wptr_gray;
    logic [PTR_WIDTH-1:0]  wptr_gray_rs;
    logic [PTR_WIDTH-1:0]  rptr_gray;
    logic [PTR_WIDTH-1:0]  rptr_gray_ws;
    logic [PTR_WIDTH-1:0]  rptr_bin;

    fifo_ctrl ctrl_i (
        .wclk         (wclk),
        .wrstn        (wrstn),
        .winc         (winc),
        .wfull        (wfull),
        .wen          (wen),
        .waddr        (waddr),
        .wptr_gray    (wptr_gray),
        .rptr_gray_ws (rptr_gray_ws),
        .rclk         (rclk),
        .rrstn        (rrstn),
        .rinc         (rinc),
        .rempty       (rempty),
        .ren          (ren),
        .raddr        (raddr),
        .rptr_bin     (rptr_bin),
        .rptr_gray    (rptr_gray),
        .wptr_gray_rs (wptr_gray_rs)
    );

    fifo_mem mem_i (
        .wclk  (wclk),
        .wen   (wen),
        .waddr (waddr),
        .wdata (wdata),
        .rclk  (rclk),
        .rrstn (rrstn),
        .ren   (ren),
        .raddr (raddr),
        .rdata (rdata)
    );

    // Write pointer into the read domain
    gray_sync w2r_sync_i (
        .dclk     (rclk),
        .drstn    (rrstn),
        .gray_in  (wptr_gray),
        .gray_out (wptr_gray_rs)
    );

    // Read pointer into the write domain
    gray_sync r2w_sync_i (
        .dclk     (wclk),
        .drstn    (wrstn),
        .gray_in  (rptr_gray),
        .gray_out (rptr_gray_ws)
    );

    fifo_level level_i (
        .rclk         (rclk),
        .rrstn        (rrstn),
        .wptr_gray_rs (wptr_gray_rs),
        .rptr_bin     (rptr_bin),
        .rlevel       (rlevel)
    );

endmodule

//--- hw/fifo_ctrl.sv
`timescale 1ns/1ps

module fifo_ctrl (
    input  logic                              wclk,
    input  logic                              wrstn,
    input  logic                              winc,
    output logic                              wfull,
    output logic                              wen,
    output logic [fifo_ptr_pkg::ADDR_WIDTH-1:0] waddr,
    output logic [fifo_ptr_pkg::PTR_WIDTH-1:0]  wptr_gray,
    input  logic [fifo_ptr_pkg::PTR_WIDTH-1:0]  rptr_gray_ws,
    input  logic                              rclk,
    input  logic                              rrstn,
    input  logic                              rinc,
    output logic                              rempty,
    output logic                              ren,
    output logic [fifo_ptr_pkg::ADDR_WIDTH-1:0] raddr,
    output logic [fifo_ptr_pkg::PTR_WIDTH-1:0]  rptr_bin,
    output logic [fifo_ptr_pkg::PTR_WIDTH-1:0]  rptr_gray,
    input  logic [fifo_ptr_pkg::PTR_WIDTH-1:0]  wptr_gray_rs
);
    import fifo_ptr_pkg::*;

    logic [PTR_WIDTH-1:0] wptr_bin;
    logic [PTR_WIDTH-1:0] wptr_gray_now;
    logic [PTR_WIDTH-1:0] full_match;
    logic [PTR_WIDTH-1:0] rptr_gray_now;

    // Write domain

    assign wptr_gray_now = wptr_bin ^ (wptr_bin >> 1);

    // Full when writer is one lap ahead, which in Gray code
    // means the two top bits differ and the rest agree
    assign full_match = {~rptr_gray_ws[PTR_WIDTH-1:PTR_WIDTH-2],
                         rptr_gray_ws[PTR_WIDTH-3:0]};

    assign wfull = (wptr_gray_now == full_match);
    assign wen   = winc && !wfull;
    assign waddr = wptr_bin[ADDR_WIDTH-1:0];

    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            wptr_bin <= '0;
        end else if (wen) begin
            wptr_bin <= wptr_bin + 1'b1;
        end
    end

    // Registered copy for the crossing into rclk
    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            wptr_gray <= '0;
        end else begin
            wptr_gray <= wptr_gray_now;
        end
    end

    // Read domain

    assign rptr_gray_now = rptr_bin ^ (rptr_bin >> 1);

    assign rempty = (rptr_gray_now == wptr_gray_rs);
    assign ren    = rinc && !rempty;
    assign raddr  = rptr_bin[ADDR_WIDTH-1:0];

    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rptr_bin <= '0;
        end else if (ren) begin
            rptr_bin <= rptr_bin + 1'b1;
        end
    end

    // Registered copy for the crossing into wclk
    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rptr_gray <= '0;
        end else begin
            rptr_gray <= rptr_gray_now;
        end
    end

endmodule

//--- hw/fifo_data_pkg.sv
package fifo_data_pkg;

    // Width of one stored word
    localparam int DATA_WIDTH = 8;

endpackage

//--- hw/fifo_level.sv
`timescale 1ns/1ps

module fifo_level (
    input  logic                               rclk,
    input  logic                               rrstn,
    input  logic [fifo_ptr_pkg::PTR_WIDTH-1:0]   wptr_gray_rs,
    input  logic [fifo_ptr_pkg::PTR_WIDTH-1:0]   rptr_bin,
    output logic [fifo_ptr_pkg::LEVEL_WIDTH-1:0] rlevel
);
    import fifo_ptr_pkg::*;

    logic [PTR_WIDTH-1:0]   wptr_bin_rs;
    logic [PTR_WIDTH-1:0]   diff;

    // Gray to binary, each bit folds in all bits above it
    always_comb begin
        wptr_bin_rs[PTR_WIDTH-1] = wptr_gray_rs[PTR_WIDTH-1];
        for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
            wptr_bin_rs[i] = wptr_bin_rs[i+1] ^ wptr_gray_rs[i];
        end
    end

    // Wraps modulo 2**PTR_WIDTH
    assign diff = wptr_bin_rs - rptr_bin;

    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rlevel <= '0;
        end else begin
            rlevel <= LEVEL_WIDTH'(diff);
        end
    end

endmodule

//--- hw/fifo_mem.sv
`timescale 1ns/1ps

module fifo_mem (
    input  logic                              wclk,
    input  logic                              wen,
    input  logic [fifo_ptr_pkg::ADDR_WIDTH-1:0]  waddr,
    input  logic [fifo_data_pkg::DATA_WIDTH-1:0] wdata,
    input  logic                              rclk,
    input  logic                              rrstn,
    input  logic                              ren,
    input  logic [fifo_ptr_pkg::ADDR_WIDTH-1:0]  raddr,
    output logic [fifo_data_pkg::DATA_WIDTH-1:0] rdata
);
    import fifo_data_pkg::*;
    import fifo_ptr_pkg::*;

    logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1];

    always_ff @(posedge wclk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Read register holds its value when no read is accepted
    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- hw/fifo_ptr_pkg.sv
package fifo_ptr_pkg;

    // Number of FIFO entries, a power of two
    localparam int FIFO_DEPTH = 16;

    // Memory address width
    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    // Address plus one wrap bit to tell full from empty
    localparam int PTR_WIDTH = ADDR_WIDTH + 1;

    // Occupancy count, holds 0 to FIFO_DEPTH
    localparam int LEVEL_WIDTH = $clog2(FIFO_DEPTH + 1);

endpackage

//--- hw/gray_sync.sv
`timescale 1ns/1ps

module gray_sync (
    input  logic                             dclk,
    input  logic                             drstn,
    input  logic [fifo_ptr_pkg::PTR_WIDTH-1:0] gray_in,
    output logic [fifo_ptr_pkg::PTR_WIDTH-1:0] gray_out
);
    import fifo_ptr_pkg::*;

    // First stage may go metastable
    logic [PTR_WIDTH-1:0] meta_q;

    // Only one bit of gray_in changes per source cycle, so the
    // captured value is always an old or a new pointer
    always_ff @(posedge dclk or negedge drstn) begin
        if (!drstn) begin
            meta_q   <= '0;
            gray_out <= '0;
        end else begin
            meta_q   <= gray_in;
            gray_out <= meta_q;
        end
    end

endmodule

//--- verif/cdc_fifo_tb.sv
`timescale 1ns/1ps

module cdc_fifo_tb;
    import fifo_data_pkg::*;
    import fifo_ptr_pkg::*;

    logic                   wclk;
    logic                   wrstn;
    logic                   winc;
    logic [DATA_WIDTH-1:0]  wdata;
    logic                   wfull;
    logic                   rclk;
    logic                   rrstn;
    logic                   rinc;
    logic [DATA_WIDTH-1:0]  rdata;
    logic                   rempty;
    logic [LEVEL_WIDTH-1:0] rlevel;

    logic [DATA_WIDTH-1:0]  model_q [$];
    logic [DATA_WIDTH-1:0]  last_read;
    logic [31:0]            lfsr_q = 32'hdd3e_1259;
    bit                     writer_done;
    int                     errors;
    int                     checks;
    int                     reads_done;
    int                     writes_done;

    cdc_fifo_top dut_i (
        .wclk   (wclk),
        .wrstn  (wrstn),
        .winc   (winc),
        .wdata  (wdata),
        .wfull  (wfull),
        .rclk   (rclk),
        .rrstn  (rrstn),
        .rinc   (rinc),
        .rdata  (rdata),
        .rempty (rempty),
        .rlevel (rlevel)
    );

    initial begin
        rclk = 1'b0;
        forever #4 rclk = ~rclk;
    end

    initial begin
        wclk = 1'b0;
        forever #5.5 wclk = ~wclk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Oldest word still held by the model
    function automatic logic [DATA_WIDTH-1:0] expected_word();
        return model_q[0];
    endfunction

    task automatic check_eq(input int got, input int exp, input string what);
        checks++;
        assert (got == exp) else begin
            $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic timeout_hit(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        $display("Test %-34s %s", name, (errors == errs_at_start) ? "ok" : "with errors");
    endtask

    // Model records every write the DUT accepts
    always @(posedge wclk) begin
        if (wrstn && winc && !wfull) begin
            model_q.push_back(wdata);
            writes_done++;
        end
    end

    always @(posedge rclk) begin : compare_reads
        logic [DATA_WIDTH-1:0] exp_word;
        if (rrstn && rinc && !rempty) begin
            if (model_q.size() == 0) begin
                $display("Read accepted at %0t although nothing was written", $time);
                errors++;
            end else begin
                exp_word = expected_word();
                void'(model_q.pop_front());
                // rdata is loaded by this edge
                @(negedge rclk);
                checks++;
                assert (rdata == exp_word) else begin
                    $display("FAILED %0t: rdata is %h, expected %h", $time, rdata, exp_word);
                    errors++;
                end
                last_read = exp_word;
                reads_done++;
            end
        end
    end

    task automatic write_burst(input int n);
        logic [31:0] bits;
        for (int i = 0; i < n; i++) begin
            @(negedge wclk);
            take_bits(DATA_WIDTH, bits);
            winc  = 1'b1;
            wdata = bits[DATA_WIDTH-1:0];
        end
        @(negedge wclk);
        winc = 1'b0;
    endtask

    task automatic drain_fifo(input string what);
        int cycles;
        int idle;
        cycles = 0;
        idle   = 0;
        @(negedge rclk);
        rinc = 1'b1;
        // Stop once rempty has stayed high longer than a pointer crossing
        while (idle < 8 && cycles < 300) begin
            @(negedge rclk);
            idle = rempty ? idle + 1 : 0;
            cycles++;
        end
        rinc = 1'b0;
        if (idle < 8) begin
            timeout_hit(what);
        end
    endtask

    task automatic random_writer(input int attempts);
        logic [31:0] bits;
        int tries;
        int cycles;
        tries  = 0;
        cycles = 0;
        while (tries < attempts && cycles < 10 * attempts) begin
            @(negedge wclk);
            take_bits(1, bits);
            winc = bits[0];
            if (bits[0]) begin
                take_bits(DATA_WIDTH, bits);
                wdata = bits[DATA_WIDTH-1:0];
                tries++;
            end
            cycles++;
        end
        @(negedge wclk);
        winc = 1'b0;
        if (tries < attempts) begin
            timeout_hit("the random writer to finish its attempts");
        end
        writer_done = 1'b1;
    endtask

    task automatic random_reader();
        logic [31:0] bits;
        int cycles;
        cycles = 0;
        // Reads at a quarter rate so the FIFO fills at times
        while (!writer_done && cycles < 20000) begin
            @(negedge rclk);
            take_bits(2, bits);
            rinc = bits[1] & bits[0];
            cycles++;
        end
        rinc = 1'b0;
        if (!writer_done) begin
            timeout_hit("the random writer while reading");
        end
    endtask

    task automatic settle_level(input string what);
        int cycles;
        cycles = 0;
        @(negedge rclk);
        while (rlevel != model_q.size() && cycles < 50) begin
            @(negedge rclk);
            cycles++;
        end
        if (cycles >= 50) begin
            timeout_hit(what);
        end
        check_eq(rlevel, model_q.size(), "rlevel");
        check_eq(rempty, model_q.size() == 0, "rempty");
        check_eq(wfull, model_q.size() == FIFO_DEPTH, "wfull");
    endtask

    initial begin : main
        int errs;
        int cycles;
        int reads_before;
        int writes_before;
        winc  = 1'b0;
        wdata = '0;
        rinc  = 1'b0;
        wrstn = 1'b0;
        rrstn = 1'b0;
        fork
            begin
                repeat (10) @(posedge wclk);
                @(negedge wclk);
                wrstn = 1'b1;
            end
            begin
                repeat (10) @(posedge rclk);
                @(negedge rclk);
                rrstn = 1'b1;
            end
        join

        errs = errors;
        check_eq(rempty, 1, "rempty after reset");
        check_eq(wfull, 0, "wfull after reset");
        check_eq(rlevel, 0, "rlevel after reset");
        report_test("1 reset values", errs);

        errs = errors;
        write_burst(FIFO_DEPTH);
        cycles = 0;
        while (!wfull && cycles < 20) begin
            @(negedge wclk);
            cycles++;
        end
        if (!wfull) begin
            timeout_hit("wfull to rise");
        end
        // These writes must be dropped
        write_burst(4);
        check_eq(model_q.size(), FIFO_DEPTH, "accepted writes while full");
        reads_before = reads_done;
        drain_fifo("the drain of a full FIFO");
        check_eq(reads_done - reads_before, FIFO_DEPTH, "words drained");
        report_test("2 fill and drop when full", errs);

        errs = errors;
        cycles = 0;
        while (!rempty && cycles < 20) begin
            @(negedge rclk);
            cycles++;
        end
        if (!rempty) begin
            timeout_hit("rempty to rise");
        end
        @(negedge rclk);
        rinc = 1'b1;
        @(negedge rclk);
        rinc = 1'b0;
        @(negedge rclk);
        check_eq(rdata, last_read, "rdata after read while empty");
        check_eq(rempty, 1, "rempty after read while empty");
        report_test("3 read while empty", errs);

        errs = errors;
        reads_before  = reads_done;
        writes_before = writes_done;
        writer_done   = 1'b0;
        fork
            random_writer(400);
            random_reader();
        join
        drain_fifo("the drain after random traffic");
        check_eq(reads_done - reads_before, writes_done - writes_before, "words read");
        report_test("4 random traffic on both sides", errs);

        errs = errors;
        write_burst(9);
        settle_level("rlevel to settle after a short burst");
        write_burst(12);
        settle_level("rlevel to settle after filling");
        report_test("5 level and flags when idle", errs);

        $display("Checks: %0d, words read: %0d, errors: %0d", checks, reads_done, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
